// ==== design/io_regs_pkg.sv ====
// shared widths and register map; the map reserves room for MAX_GPIO_PORTS ports of 3 words
`default_nettype none

package io_regs_pkg;

    // ========================================================================
    // bus widths
    // ========================================================================
    localparam int BUS_WIDTH      = 32;     // host data width
    localparam int ADDR_WIDTH     = 16;     // host byte address width
    localparam int MAX_GPIO_PORTS = 4;      // register map sized for this many

    typedef logic [BUS_WIDTH-1:0]  word_t;       // one bus word
    typedef logic [ADDR_WIDTH-3:0] word_addr_t;  // word address, byte bits dropped
    typedef logic [31:0]           gpio_word_t;  // pins of one gpio port
    typedef logic [1:0]            button_t;     // key levels, active low
    typedef logic [7:0]            irq_vec_t;    // [1:0] keys, [2+p] gpio port p

    // read-only identification word ("IO" + revision)
    localparam word_t IO_BLOCK_ID = 32'h494f_0102;

    // ========================================================================
    // register word indices
    // ========================================================================
    localparam word_addr_t REG_ID         = word_addr_t'(0);
    localparam word_addr_t REG_BUTTONS    = word_addr_t'(1);
    localparam word_addr_t REG_IRQ_STATUS = word_addr_t'(2);  // write 1 to clear
    localparam word_addr_t REG_IRQ_MASK   = word_addr_t'(3);
    localparam word_addr_t REG_GPIO_BASE  = word_addr_t'(4);  // port p at base + 3*p

    // register within a gpio port, in address order
    localparam logic [1:0] GPIO_SEL_OUT = 2'd0;   // data out
    localparam logic [1:0] GPIO_SEL_DIR = 2'd1;   // direction, 1 = drive
    localparam logic [1:0] GPIO_SEL_IN  = 2'd2;   // synchronized pins, read only

    // per-key debounce fsm
    typedef enum logic {
        DB_STABLE,      // input agrees with settled level
        DB_COUNTING     // input differs, timing the new level
    } db_state_t;

endpackage

`default_nettype wire

// ==== design/button_debounce.sv ====
// keys are active low and read all ones when released; DEBOUNCE_CYCLES must be 2 or more
`timescale 1ns/10ps
`default_nettype none

module button_debounce #(
    parameter int DEBOUNCE_CYCLES = 50000            // 1 ms at 50 MHz
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire io_regs_pkg::button_t key_in,        // raw key pins, async
    output io_regs_pkg::button_t      buttons_db,    // settled levels
    output io_regs_pkg::button_t      button_changed // one pulse per settled edge
);
    import io_regs_pkg::*;

    localparam int NUM_KEYS = $bits(button_t);
    localparam int CNT_W    = $clog2(DEBOUNCE_CYCLES + 1);

    button_t          sync1_q;              // first synchronizer stage
    button_t          sync2_q;              // safe to use from here on
    db_state_t        state_q [NUM_KEYS];
    logic [CNT_W-1:0] cnt_q   [NUM_KEYS];   // cycles the input has differed

    // two-flop synchronizer, idles at the released level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= '1;
            sync2_q <= '1;
        end else begin
            sync1_q <= key_in;
            sync2_q <= sync1_q;
        end
    end

    // ========================================================================
    // debounce fsm, one per key
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buttons_db     <= '1;   // released
            button_changed <= '0;
            for (int i = 0; i < NUM_KEYS; i++) begin
                state_q[i] <= DB_STABLE;
                cnt_q[i]   <= '0;
            end
        end else begin
            button_changed <= '0;   // pulse only
            for (int i = 0; i < NUM_KEYS; i++) begin
                case (state_q[i])
                    DB_STABLE: begin
                        if (sync2_q[i] != buttons_db[i]) begin
                            state_q[i] <= DB_COUNTING;
                            cnt_q[i]   <= CNT_W'(1);   // first differing cycle
                        end
                    end
                    DB_COUNTING: begin
                        if (sync2_q[i] == buttons_db[i]) begin
                            state_q[i] <= DB_STABLE;   // glitch, back to old level
                            cnt_q[i]   <= '0;
                        end else if (cnt_q[i] >= CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                            buttons_db[i]     <= sync2_q[i];   // adopt new level
                            button_changed[i] <= 1'b1;
                            state_q[i]        <= DB_STABLE;
                            cnt_q[i]          <= '0;
                        end else begin
                            cnt_q[i] <= cnt_q[i] + 1'b1;
                        end
                    end
                    default: state_q[i] <= DB_STABLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/gpio_port_regs.sv ====
// NUM_GPIO_PORTS is 1 to 4; input changes within 2 cycles of each other can share one flag pulse
`timescale 1ns/10ps
`default_nettype none

module gpio_port_regs #(
    parameter int NUM_GPIO_PORTS = 2
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    gpio_wr,       // qualified write pulse
    input  wire logic [1:0]              gpio_port_sel, // target port
    input  wire logic [1:0]              gpio_reg_sel,  // out / dir / in
    input  wire io_regs_pkg::word_t      wr_data,
    input  wire io_regs_pkg::gpio_word_t gpio_in       [NUM_GPIO_PORTS],
    output io_regs_pkg::gpio_word_t      gpio_out      [NUM_GPIO_PORTS],
    output io_regs_pkg::gpio_word_t      gpio_oe       [NUM_GPIO_PORTS],
    output io_regs_pkg::gpio_word_t      gpio_in_regs  [NUM_GPIO_PORTS],
    output logic [NUM_GPIO_PORTS-1:0]    gpio_changed   // one pulse per port
);
    import io_regs_pkg::*;

    gpio_word_t sync1_q [NUM_GPIO_PORTS];   // first synchronizer stage
    gpio_word_t prev_q  [NUM_GPIO_PORTS];   // last sample of gpio_in_regs

    // ========================================================================
    // host-writable registers
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_GPIO_PORTS; p++) begin
                gpio_out[p] <= '0;
                gpio_oe[p]  <= '0;      // all pins start as inputs
            end
        end else if (gpio_wr) begin
            for (int p = 0; p < NUM_GPIO_PORTS; p++) begin
                if (gpio_port_sel == 2'(p)) begin
                    if (gpio_reg_sel == GPIO_SEL_OUT) begin
                        gpio_out[p] <= wr_data;
                    end
                    if (gpio_reg_sel == GPIO_SEL_DIR) begin
                        gpio_oe[p] <= wr_data;
                    end
                    // GPIO_SEL_IN is read only, nothing to store
                end
            end
        end
    end

    // ========================================================================
    // input synchronizer and change detect
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_changed <= '0;
            for (int p = 0; p < NUM_GPIO_PORTS; p++) begin
                sync1_q[p]      <= '0;
                gpio_in_regs[p] <= '0;
                prev_q[p]       <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_GPIO_PORTS; p++) begin
                sync1_q[p]      <= gpio_in[p];
                gpio_in_regs[p] <= sync1_q[p];       // pins visible 2 cycles on
                prev_q[p]       <= gpio_in_regs[p];
                // any bit moved since last sample
                gpio_changed[p] <= (gpio_in_regs[p] != prev_q[p]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/irq_ctrl.sv ====
// status bits are sticky until written with a one; a new event in the clear cycle keeps its bit
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl #(
    parameter int NUM_GPIO_PORTS = 2
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire io_regs_pkg::button_t      button_changed,  // key edge pulses
    input  wire logic [NUM_GPIO_PORTS-1:0] gpio_changed,    // port change pulses
    input  wire logic                      mask_wr,         // write to REG_IRQ_MASK
    input  wire logic                      status_clr_wr,   // write to REG_IRQ_STATUS
    input  wire io_regs_pkg::word_t        wr_data,
    output io_regs_pkg::irq_vec_t          irq_status,
    output io_regs_pkg::irq_vec_t          irq_mask,
    output logic                           irq              // level, to host
);
    import io_regs_pkg::*;

    localparam int GPIO_LSB = $bits(button_t);   // gpio bits follow the keys

    irq_vec_t src;   // this cycle's events
    irq_vec_t clr;   // bits the host wants cleared

    always_comb begin
        src = '0;
        src[GPIO_LSB-1:0]              = button_changed;
        src[GPIO_LSB +: NUM_GPIO_PORTS] = gpio_changed;
    end

    assign clr = status_clr_wr ? wr_data[$bits(irq_vec_t)-1:0] : '0;

    // ========================================================================
    // status, mask and interrupt line
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_status <= '0;
            irq_mask   <= '0;
            irq        <= 1'b0;
        end else begin
            irq_status <= (irq_status & ~clr) | src;   // set beats clear
            if (mask_wr) begin
                irq_mask <= wr_data[$bits(irq_vec_t)-1:0];
            end
            irq <= |(irq_status & irq_mask);           // one cycle behind status
        end
    end

endmodule

`default_nettype wire

// ==== design/bus_decoder.sv ====
// single bus master, no wait states; words of ports at or above NUM_GPIO_PORTS read zero
`timescale 1ns/10ps
`default_nettype none

module bus_decoder #(
    parameter int NUM_GPIO_PORTS = 2
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    chip_sel,
    input  wire logic                    hm_read,      // one-cycle strobe
    input  wire logic                    hm_write,     // one-cycle strobe
    input  wire io_regs_pkg::word_addr_t hm_address,
    input  wire io_regs_pkg::button_t    buttons_db,
    input  wire io_regs_pkg::gpio_word_t gpio_out_regs [NUM_GPIO_PORTS],
    input  wire io_regs_pkg::gpio_word_t gpio_dir_regs [NUM_GPIO_PORTS],
    input  wire io_regs_pkg::gpio_word_t gpio_in_regs  [NUM_GPIO_PORTS],
    input  wire io_regs_pkg::irq_vec_t   irq_status,
    input  wire io_regs_pkg::irq_vec_t   irq_mask,
    output logic                         gpio_wr,
    output logic [1:0]                   gpio_port_sel,
    output logic [1:0]                   gpio_reg_sel,
    output logic                         mask_wr,
    output logic                         status_clr_wr,
    output io_regs_pkg::word_t           busdata_out    // held until next read
);
    import io_regs_pkg::*;

    logic  rd_en;        // strobes qualified by chip select
    logic  wr_en;
    logic  gpio_hit;     // address falls on a populated gpio port
    word_t rd_mux;

    assign rd_en = chip_sel & hm_read;
    assign wr_en = chip_sel & hm_write;

    // ========================================================================
    // gpio window, 3 words per port
    // ========================================================================
    always_comb begin
        gpio_hit      = 1'b0;
        gpio_port_sel = '0;
        gpio_reg_sel  = '0;
        for (int p = 0; p < MAX_GPIO_PORTS; p++) begin
            for (int r = 0; r < 3; r++) begin
                if (hm_address == word_addr_t'(REG_GPIO_BASE + 3 * p + r)) begin
                    gpio_hit      = (p < NUM_GPIO_PORTS);   // reserved ports stay dead
                    gpio_port_sel = 2'(p);
                    gpio_reg_sel  = 2'(r);
                end
            end
        end
    end

    assign gpio_wr       = wr_en & gpio_hit;
    assign mask_wr       = wr_en & (hm_address == REG_IRQ_MASK);
    assign status_clr_wr = wr_en & (hm_address == REG_IRQ_STATUS);

    // read-back mux
    always_comb begin
        rd_mux = '0;    // unmapped words read zero
        case (hm_address)
            REG_ID:         rd_mux = IO_BLOCK_ID;
            REG_BUTTONS:    rd_mux = word_t'(buttons_db);
            REG_IRQ_STATUS: rd_mux = word_t'(irq_status);
            REG_IRQ_MASK:   rd_mux = word_t'(irq_mask);
            default: begin
                if (gpio_hit) begin
                    case (gpio_reg_sel)
                        GPIO_SEL_OUT: rd_mux = gpio_out_regs[int'(gpio_port_sel)];
                        GPIO_SEL_DIR: rd_mux = gpio_dir_regs[int'(gpio_port_sel)];
                        GPIO_SEL_IN:  rd_mux = gpio_in_regs[int'(gpio_port_sel)];
                        default:      rd_mux = '0;
                    endcase
                end
            end
        endcase
    end

    // data valid the cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busdata_out <= '0;
        end else if (rd_en) begin
            busdata_out <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== design/fpga_io_top.sv ====
// one 50 MHz clock domain; pins come as separate out, oe and in ports, tristating is left to the pad ring
`timescale 1ns/10ps
`default_nettype none

module fpga_io_top #(
    parameter int NUM_GPIO_PORTS  = 2,        // 1 to 4
    parameter int DEBOUNCE_CYCLES = 50000     // 1 ms at 50 MHz
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    chip_sel,
    input  wire logic                    hm_read,
    input  wire logic                    hm_write,
    input  wire io_regs_pkg::word_addr_t hm_address,
    input  wire io_regs_pkg::word_t      hm_datai,     // host write data
    input  wire io_regs_pkg::button_t    key_in,
    input  wire io_regs_pkg::gpio_word_t gpio_in     [NUM_GPIO_PORTS],
    output wire io_regs_pkg::word_t      busdata_out,  // host read data
    output wire io_regs_pkg::gpio_word_t gpio_out    [NUM_GPIO_PORTS],
    output wire io_regs_pkg::gpio_word_t gpio_oe     [NUM_GPIO_PORTS],
    output wire logic                    irq
);
    import io_regs_pkg::*;

    // ========================================================================
    // peer wiring
    // ========================================================================
    button_t                   buttons_db;
    button_t                   button_changed;
    gpio_word_t                gpio_in_regs [NUM_GPIO_PORTS];
    logic [NUM_GPIO_PORTS-1:0] gpio_changed;
    logic                      gpio_wr;
    logic [1:0]                gpio_port_sel;
    logic [1:0]                gpio_reg_sel;
    logic                      mask_wr;
    logic                      status_clr_wr;
    irq_vec_t                  irq_status;
    irq_vec_t                  irq_mask;

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_button_debounce (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_in         (key_in),
        .buttons_db     (buttons_db),       // to read-back
        .button_changed (button_changed)    // to irq
    );

    gpio_port_regs #(.NUM_GPIO_PORTS(NUM_GPIO_PORTS)) u_gpio_port_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .gpio_wr       (gpio_wr),
        .gpio_port_sel (gpio_port_sel),
        .gpio_reg_sel  (gpio_reg_sel),
        .wr_data       (hm_datai),
        .gpio_in       (gpio_in),
        .gpio_out      (gpio_out),          // data-out regs drive pins directly
        .gpio_oe       (gpio_oe),
        .gpio_in_regs  (gpio_in_regs),
        .gpio_changed  (gpio_changed)
    );

    irq_ctrl #(.NUM_GPIO_PORTS(NUM_GPIO_PORTS)) u_irq_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .button_changed (button_changed),
        .gpio_changed   (gpio_changed),
        .mask_wr        (mask_wr),
        .status_clr_wr  (status_clr_wr),
        .wr_data        (hm_datai),
        .irq_status     (irq_status),
        .irq_mask       (irq_mask),
        .irq            (irq)
    );

    bus_decoder #(.NUM_GPIO_PORTS(NUM_GPIO_PORTS)) u_bus_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .chip_sel      (chip_sel),
        .hm_read       (hm_read),
        .hm_write      (hm_write),
        .hm_address    (hm_address),
        .buttons_db    (buttons_db),
        .gpio_out_regs (gpio_out),          // read back what the pins see
        .gpio_dir_regs (gpio_oe),
        .gpio_in_regs  (gpio_in_regs),
        .irq_status    (irq_status),
        .irq_mask      (irq_mask),
        .gpio_wr       (gpio_wr),
        .gpio_port_sel (gpio_port_sel),
        .gpio_reg_sel  (gpio_reg_sel),
        .mask_wr       (mask_wr),
        .status_clr_wr (status_clr_wr),
        .busdata_out   (busdata_out)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// free-running testbench clock, 4 ns period; rst_n is released on a falling edge after RESET_CYCLES
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2,   // 4 ns period
    parameter int RESET_CYCLES   = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;                       // asserted from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                     // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tb_fpga_io.sv ====
// directed tests of fpga_io_top, 2 gpio ports, 8-cycle debounce; inputs change on falling edges
`timescale 1ns/10ps
`default_nettype none

module tb_fpga_io;
    import io_regs_pkg::*;

    localparam int NUM_PORTS  = 2;
    localparam int DB_CYCLES  = 8;     // short debounce keeps runs fast
    localparam int POLL_LIMIT = 40;    // reads or cycles before a wait gives up

    logic       clk;
    logic       rst_n;
    logic       chip_sel;
    logic       hm_read;
    logic       hm_write;
    word_addr_t hm_address;
    word_t      hm_datai;
    button_t    key_in;
    gpio_word_t gpio_in  [NUM_PORTS];
    word_t      busdata_out;
    gpio_word_t gpio_out [NUM_PORTS];
    gpio_word_t gpio_oe  [NUM_PORTS];
    logic       irq;

    integer seed = 41;
    int     error_count = 0;
    int     check_count = 0;
    int     test_count  = 0;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    fpga_io_top #(.NUM_GPIO_PORTS(NUM_PORTS), .DEBOUNCE_CYCLES(DB_CYCLES)) dut (
        .clk(clk), .rst_n(rst_n), .chip_sel(chip_sel), .hm_read(hm_read),
        .hm_write(hm_write), .hm_address(hm_address), .hm_datai(hm_datai),
        .key_in(key_in), .gpio_in(gpio_in), .busdata_out(busdata_out),
        .gpio_out(gpio_out), .gpio_oe(gpio_oe), .irq(irq)
    );

    // ========================================================================
    // compare tasks
    // ========================================================================
    task automatic check_word(input word_t got, input word_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s read %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_gpio(input gpio_word_t got, input gpio_word_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_buttons(input button_t got, input button_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s irq is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // ========================================================================
    // bus and wait helpers
    // ========================================================================
    // port p owns words base + 3p .. base + 3p + 2
    function automatic word_addr_t gpio_addr(input int port, input int sel);
        return word_addr_t'(REG_GPIO_BASE + 3 * port + sel);
    endfunction

    task automatic bus_write(input word_addr_t addr, input word_t data);
        @(negedge clk);
        chip_sel   = 1'b1;
        hm_write   = 1'b1;
        hm_address = addr;
        hm_datai   = data;
        @(negedge clk);                 // register took it on the edge between
        hm_write   = 1'b0;
        chip_sel   = 1'b0;
    endtask

    task automatic bus_read(input word_addr_t addr, input logic cs, output word_t data);
        @(negedge clk);
        chip_sel   = cs;
        hm_read    = 1'b1;
        hm_address = addr;
        @(negedge clk);
        hm_read    = 1'b0;
        chip_sel   = 1'b0;
        data       = busdata_out;       // one cycle after the strobe
    endtask

    task automatic poll_reg(input word_addr_t addr, input word_t exp, output word_t got);
        int n;
        n = 0;
        bus_read(addr, 1'b1, got);
        while (got !== exp && n < POLL_LIMIT) begin
            bus_read(addr, 1'b1, got);
            n++;
        end
        if (got !== exp) begin
            $display("timeout: register word %0d never read back %h", addr, exp);
            error_count++;
        end
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (irq !== level && n < POLL_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (irq !== level) begin
            $display("timeout: irq never went to %b", level);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("%s finished with %0d errors", name, error_count - errs_before);
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic reset_and_id();
        int    errs;
        word_t d;
        errs = error_count;
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_gpio(gpio_out[p], '0, "gpio_out after reset");
            check_gpio(gpio_oe[p], '0, "gpio_oe after reset");   // all inputs
        end
        check_irq(irq, 1'b0, "after reset");
        bus_read(REG_ID, 1'b1, d);
        check_word(d, IO_BLOCK_ID, "REG_ID");
        bus_read(word_addr_t'(100), 1'b1, d);
        check_word(d, '0, "unmapped word");
        bus_read(REG_ID, 1'b1, d);                              // nonzero before next read
        bus_read(gpio_addr(3, 0), 1'b1, d);                     // reserved port 3
        check_word(d, '0, "unpopulated port");
        bus_read(REG_ID, 1'b1, d);
        bus_read(word_addr_t'(100), 1'b0, d);                   // chip_sel low, ignored
        check_word(d, IO_BLOCK_ID, "read without chip_sel");
        report_test("reset_and_id", errs);
    endtask

    task automatic gpio_output_regs();
        int         errs;
        word_t      d;
        gpio_word_t exp_out [NUM_PORTS];
        gpio_word_t exp_oe  [NUM_PORTS];
        errs = error_count;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_out[p] = $random(seed);
            exp_oe[p]  = $random(seed);
            bus_write(gpio_addr(p, 0), exp_out[p]);
            check_gpio(gpio_out[p], exp_out[p], "gpio_out next cycle");
            bus_write(gpio_addr(p, 1), exp_oe[p]);
            check_gpio(gpio_oe[p], exp_oe[p], "gpio_oe next cycle");
        end
        for (int p = 0; p < NUM_PORTS; p++) begin    // other port left alone
            check_gpio(gpio_out[p], exp_out[p], "gpio_out after all writes");
            bus_read(gpio_addr(p, 0), 1'b1, d);
            check_word(d, exp_out[p], "data-out register");
            bus_read(gpio_addr(p, 1), 1'b1, d);
            check_word(d, exp_oe[p], "direction register");
        end
        report_test("gpio_output_regs", errs);
    endtask

    task automatic gpio_input_sync();
        int         errs;
        word_t      d;
        gpio_word_t v;
        errs = error_count;
        for (int p = 0; p < NUM_PORTS; p++) begin
            v = $random(seed);
            if (v == gpio_in[p]) v = ~v;           // force a real change
            @(negedge clk);
            gpio_in[p] = v;
            poll_reg(gpio_addr(p, 2), v, d);
            check_word(d, v, "input register");
        end
        report_test("gpio_input_sync", errs);
    endtask

    task automatic key_debounce();
        int      errs;
        word_t   d;
        button_t worst;
        errs  = error_count;
        worst = 2'b11;
        @(negedge clk);
        key_in = 2'b10;                            // key 0 glitch, 3 cycles
        repeat (3) @(negedge clk);
        key_in = 2'b11;
        for (int i = 0; i < 10; i++) begin         // about 20 cycles of watching
            bus_read(REG_BUTTONS, 1'b1, d);
            if (d[1:0] != 2'b11) worst = d[1:0];
        end
        check_buttons(worst, 2'b11, "buttons after glitch");
        @(negedge clk);
        key_in = 2'b10;                            // held press
        poll_reg(REG_BUTTONS, 32'h2, d);
        check_buttons(d[1:0], 2'b10, "buttons after press");
        key_in = 2'b11;
        poll_reg(REG_BUTTONS, 32'h3, d);
        check_buttons(d[1:0], 2'b11, "buttons after release");
        report_test("key_debounce", errs);
    endtask

    task automatic irq_flow();
        int    errs;
        word_t d;
        errs = error_count;
        bus_write(REG_IRQ_MASK, '0);
        bus_write(REG_IRQ_STATUS, 32'hff);         // drop earlier events
        bus_read(REG_IRQ_STATUS, 1'b1, d);
        check_word(d, '0, "status after clear all");
        @(negedge clk);
        gpio_in[1] = ~gpio_in[1];                  // port 1 is status bit 3
        poll_reg(REG_IRQ_STATUS, 32'h08, d);
        check_word(d, 32'h08, "status after port 1 change");
        check_irq(irq, 1'b0, "masked");
        bus_write(REG_IRQ_MASK, 32'h08);
        wait_irq(1'b1);
        check_irq(irq, 1'b1, "unmasked");
        bus_write(REG_IRQ_STATUS, 32'h08);
        wait_irq(1'b0);
        check_irq(irq, 1'b0, "after status clear");
        bus_read(REG_IRQ_STATUS, 1'b1, d);
        check_word(d, '0, "status after clear");
        @(negedge clk);
        key_in = 2'b01;                            // key 1 press, status bit 1
        poll_reg(REG_IRQ_STATUS, 32'h02, d);
        check_word(d, 32'h02, "status after key 1");
        check_irq(irq, 1'b0, "key bit masked");
        key_in = 2'b11;
        poll_reg(REG_BUTTONS, 32'h3, d);
        report_test("irq_flow", errs);
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        int n;
        chip_sel   = 1'b0;
        hm_read    = 1'b0;
        hm_write   = 1'b0;
        hm_address = '0;
        hm_datai   = '0;
        key_in     = 2'b11;                        // released
        for (int p = 0; p < NUM_PORTS; p++) gpio_in[p] = '0;
        n = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            error_count++;
        end
        reset_and_id();
        gpio_output_regs();
        gpio_input_sync();
        key_debounce();
        irq_flow();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/io_regs_pkg.sv
design/button_debounce.sv
design/gpio_port_regs.sv
design/irq_ctrl.sv
design/bus_decoder.sv
design/fpga_io_top.sv
tests/tb_clock.sv
tests/tb_fpga_io.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_fpga_io
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# show the simulation output, then fail unless the pass line is in it
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
